// File: design/tcp_pkg.sv
/*
 * Shared TCP header constants and types.
 * Only option-free 20-byte headers are supported, so data offset is fixed at 5.
 * Checksum and urgent pointer are not carried in tcp_seg_t.
 */
package tcp_pkg;

    localparam int          HEADER_BYTES = 20;
    localparam logic [3:0]  DATA_OFFSET  = 4'd5;     // 32-bit words
    localparam logic [15:0] WINDOW_SIZE  = 16'hffff;

    typedef struct packed {
        logic urg;
        logic ack;
        logic psh;
        logic rst;
        logic syn;
        logic fin;
    } tcp_flags_t;

    // flag sets the client sends
    localparam tcp_flags_t FLAG_SYN     = 6'b00_0010;
    localparam tcp_flags_t FLAG_ACK     = 6'b01_0000;
    localparam tcp_flags_t FLAG_FIN_ACK = 6'b01_0001;

    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [31:0] seq;
        logic [31:0] ack;
        tcp_flags_t  flags;
        logic [15:0] window;
    } tcp_seg_t;

    typedef enum logic [2:0] {
        ST_IDLE        = 3'd0,
        ST_SYN_SENT    = 3'd1,
        ST_ESTABLISHED = 3'd2,
        ST_FIN_WAIT    = 3'd3,
        ST_TIME_WAIT   = 3'd4,
        ST_CLOSING     = 3'd5
    } tcp_state_e;

endpackage

// File: design/tcp_header_rx.sv
/*
 * Receive header parser. Assumes a 20-byte header without options.
 * Checksum is not verified and payload bytes are skipped.
 * Frames shorter than 20 bytes are dropped; a sop restarts the count.
 */
`timescale 1ns/1ps

module tcp_header_rx (
    input  logic              clk,
    input  logic              rst,
    input  logic [7:0]        din,
    input  logic              din_vld,
    input  logic              din_sop,
    input  logic              din_eop,
    output tcp_pkg::tcp_seg_t rx_seg,
    output logic              rx_seg_vld
);
    localparam logic [4:0] LAST = 5'(tcp_pkg::HEADER_BYTES - 1);

    logic [4:0] cnt;       // bytes taken so far, saturates at 20
    logic [4:0] idx;       // position of the current byte
    logic       in_frame;
    logic       take;

    assign idx  = din_sop ? 5'd0 : cnt;
    assign take = din_vld && (din_sop || in_frame);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt        <= 5'd0;
            in_frame   <= 1'b0;
            rx_seg_vld <= 1'b0;
        end else begin
            rx_seg_vld <= take && din_eop && (idx >= LAST);
            if (take) begin
                in_frame <= !din_eop;
                if (idx <= LAST) begin
                    cnt <= idx + 5'd1;
                end
            end
        end
    end

    // header fields shift in msb first
    always_ff @(posedge clk) begin
        if (take) begin
            case (idx)
                5'd0, 5'd1: rx_seg.src_port <= {rx_seg.src_port[7:0], din};
                5'd2, 5'd3: rx_seg.dst_port <= {rx_seg.dst_port[7:0], din};
                5'd4, 5'd5, 5'd6, 5'd7: rx_seg.seq <= {rx_seg.seq[23:0], din};
                5'd8, 5'd9, 5'd10, 5'd11: rx_seg.ack <= {rx_seg.ack[23:0], din};
                5'd13: rx_seg.flags <= din[5:0];               // reserved bits dropped
                5'd14, 5'd15: rx_seg.window <= {rx_seg.window[7:0], din};
                default: ;                                     // offset, csum, urg, payload
            endcase
        end
    end

endmodule

// File: design/tcp_header_tx.sv
/*
 * Transmit header serialiser. Emits exactly 20 bytes per segment, no options.
 * Checksum and urgent pointer are sent as zero.
 * tx_start is ignored while a frame is in flight; there is no ready input.
 */
`timescale 1ns/1ps

module tcp_header_tx (
    input  logic              clk,
    input  logic              rst,
    input  tcp_pkg::tcp_seg_t tx_seg,
    input  logic              tx_start,
    output logic              tx_busy,
    output logic [7:0]        dout,
    output logic              dout_vld,
    output logic              dout_sop,
    output logic              dout_eop
);
    localparam logic [4:0] LAST = 5'(tcp_pkg::HEADER_BYTES - 1);

    tcp_pkg::tcp_seg_t seg;   // latched on start
    logic [4:0]        idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_busy <= 1'b0;
            idx     <= 5'd0;
        end else if (tx_busy) begin
            idx <= idx + 5'd1;
            if (idx == LAST) begin
                tx_busy <= 1'b0;
            end
        end else if (tx_start) begin
            tx_busy <= 1'b1;
            idx     <= 5'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_start && !tx_busy) begin
            seg <= tx_seg;
        end
    end

    assign dout_vld = tx_busy;
    assign dout_sop = tx_busy && (idx == 5'd0);
    assign dout_eop = tx_busy && (idx == LAST);

    always_comb begin
        case (idx)
            5'd0:    dout = seg.src_port[15:8];
            5'd1:    dout = seg.src_port[7:0];
            5'd2:    dout = seg.dst_port[15:8];
            5'd3:    dout = seg.dst_port[7:0];
            5'd4:    dout = seg.seq[31:24];
            5'd5:    dout = seg.seq[23:16];
            5'd6:    dout = seg.seq[15:8];
            5'd7:    dout = seg.seq[7:0];
            5'd8:    dout = seg.ack[31:24];
            5'd9:    dout = seg.ack[23:16];
            5'd10:   dout = seg.ack[15:8];
            5'd11:   dout = seg.ack[7:0];
            5'd12:   dout = {tcp_pkg::DATA_OFFSET, 4'h0};
            5'd13:   dout = {2'b00, seg.flags};
            5'd14:   dout = seg.window[15:8];
            5'd15:   dout = seg.window[7:0];
            default: dout = 8'h00;                 // checksum and urgent pointer
        endcase
    end

endmodule

// File: design/tcp_conn_ctrl.sv
/*
 * Client connection FSM with sequence and ack bookkeeping.
 * Active open and active close only; a server FIN while established is ignored.
 * No retransmission: a segment that arrives while the serialiser is busy is lost.
 */
`timescale 1ns/1ps

module tcp_conn_ctrl #(
    parameter logic [15:0] SERVER_PORT = 16'd6000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                open,
    input  logic                close,
    input  logic [15:0]         client_port,
    input  tcp_pkg::tcp_seg_t   rx_seg,
    input  logic                rx_seg_vld,
    input  logic                tx_busy,
    output tcp_pkg::tcp_seg_t   tx_seg,
    output logic                tx_start,
    output tcp_pkg::tcp_state_e state
);
    tcp_pkg::tcp_state_e state_nxt;
    tcp_pkg::tcp_flags_t send_flags;
    logic [31:0]         snd_nxt;
    logic [31:0]         rcv_nxt;
    logic [31:0]         snd_nxt_d;
    logic [31:0]         rcv_nxt_d;
    logic [31:0]         send_seq;
    logic [31:0]         peer_nxt;
    logic                can_send;
    logic                ack_ok;
    logic                send;

    assign can_send = !tx_busy && !tx_start;    // start of last cycle not yet seen as busy
    assign ack_ok   = rx_seg.flags.ack && (rx_seg.ack == snd_nxt);
    assign peer_nxt = rx_seg.seq + 32'd1;

    always_comb begin
        state_nxt  = state;
        snd_nxt_d  = snd_nxt;
        rcv_nxt_d  = rcv_nxt;
        send       = 1'b0;
        send_flags = tcp_pkg::FLAG_ACK;
        send_seq   = snd_nxt;
        if (rx_seg_vld && rx_seg.flags.rst && state != tcp_pkg::ST_IDLE) begin
            state_nxt = tcp_pkg::ST_IDLE;                   // abort, nothing sent
        end else begin
            case (state)
                tcp_pkg::ST_IDLE: begin
                    if (open && can_send) begin
                        send       = 1'b1;
                        send_flags = tcp_pkg::FLAG_SYN;
                        send_seq   = 32'd0;
                        snd_nxt_d  = 32'd1;
                        rcv_nxt_d  = 32'd0;
                        state_nxt  = tcp_pkg::ST_SYN_SENT;
                    end
                end
                tcp_pkg::ST_SYN_SENT: begin
                    if (rx_seg_vld && can_send && ack_ok && rx_seg.flags.syn) begin
                        send      = 1'b1;
                        rcv_nxt_d = peer_nxt;
                        state_nxt = tcp_pkg::ST_ESTABLISHED;
                    end
                end
                tcp_pkg::ST_ESTABLISHED: begin
                    if (close && can_send) begin
                        send       = 1'b1;
                        send_flags = tcp_pkg::FLAG_FIN_ACK;
                        snd_nxt_d  = snd_nxt + 32'd1;          // FIN takes one seq
                        state_nxt  = tcp_pkg::ST_FIN_WAIT;
                    end
                end
                tcp_pkg::ST_FIN_WAIT: begin
                    if (rx_seg_vld && ack_ok) begin
                        if (!rx_seg.flags.fin) begin
                            state_nxt = tcp_pkg::ST_TIME_WAIT;  // split close, FIN later
                        end else if (can_send) begin
                            send      = 1'b1;
                            rcv_nxt_d = peer_nxt;
                            state_nxt = tcp_pkg::ST_CLOSING;
                        end
                    end
                end
                tcp_pkg::ST_TIME_WAIT: begin
                    if (rx_seg_vld && can_send && rx_seg.flags.fin) begin
                        send      = 1'b1;
                        rcv_nxt_d = peer_nxt;
                        state_nxt = tcp_pkg::ST_CLOSING;
                    end
                end
                tcp_pkg::ST_CLOSING: begin
                    if (can_send) begin
                        state_nxt = tcp_pkg::ST_IDLE;          // final ACK is out
                    end
                end
                default: state_nxt = tcp_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= tcp_pkg::ST_IDLE;
            snd_nxt  <= 32'd0;
            rcv_nxt  <= 32'd0;
            tx_start <= 1'b0;
        end else begin
            state    <= state_nxt;
            snd_nxt  <= snd_nxt_d;
            rcv_nxt  <= rcv_nxt_d;
            tx_start <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            tx_seg.src_port <= client_port;
            tx_seg.dst_port <= SERVER_PORT;
            tx_seg.seq      <= send_seq;
            tx_seg.ack      <= rcv_nxt_d;                    // zero for the SYN
            tx_seg.flags    <= send_flags;
            tx_seg.window   <= tcp_pkg::WINDOW_SIZE;
        end
    end

endmodule

// File: design/tcp_client_top.sv
/*
 * TCP client connection engine, header-only segments.
 * client_port must stay stable while a connection is open.
 * No back-pressure: input must not arrive while dout_vld is high.
 */
`timescale 1ns/1ps

module tcp_client_top #(
    parameter logic [15:0] SERVER_PORT = 16'd6000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [7:0]          din,
    input  logic                din_vld,
    input  logic                din_sop,
    input  logic                din_eop,
    input  logic                open,
    input  logic                close,
    input  logic [15:0]         client_port,
    output logic [7:0]          dout,
    output logic                dout_vld,
    output logic                dout_sop,
    output logic                dout_eop,
    output tcp_pkg::tcp_state_e state
);
    tcp_pkg::tcp_seg_t rx_seg;
    tcp_pkg::tcp_seg_t tx_seg;
    logic              rx_seg_vld;
    logic              tx_start;
    logic              tx_busy;

    tcp_header_rx i_header_rx (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .din_vld    (din_vld),
        .din_sop    (din_sop),
        .din_eop    (din_eop),
        .rx_seg     (rx_seg),
        .rx_seg_vld (rx_seg_vld)
    );

    tcp_conn_ctrl #(
        .SERVER_PORT (SERVER_PORT)
    ) i_conn_ctrl (
        .clk         (clk),
        .rst         (rst),
        .open        (open),
        .close       (close),
        .client_port (client_port),
        .rx_seg      (rx_seg),
        .rx_seg_vld  (rx_seg_vld),
        .tx_busy     (tx_busy),
        .tx_seg      (tx_seg),
        .tx_start    (tx_start),
        .state       (state)
    );

    tcp_header_tx i_header_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_seg   (tx_seg),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .dout     (dout),
        .dout_vld (dout_vld),
        .dout_sop (dout_sop),
        .dout_eop (dout_eop)
    );

endmodule

// File: verification/tcp_client_tb.sv
/*
 * Testbench for the TCP client engine with a small server model in procedural code.
 * Segments are header-only; random gaps, ISNs, ports and payload tails come from xorshift.
 * Frames are sampled on the falling edge, inputs change on the rising edge.
 */
`timescale 1ns/1ps

module tcp_client_tb;

    localparam logic [15:0] SERVER_PORT = 16'd6000;
    localparam logic [5:0]  F_FIN       = 6'b000001;
    localparam logic [5:0]  F_SYN       = 6'b000010;
    localparam logic [5:0]  F_RST       = 6'b000100;
    localparam logic [5:0]  F_ACK       = 6'b010000;

    logic                clk;
    logic                rst;
    logic [7:0]          din;
    logic                din_vld;
    logic                din_sop;
    logic                din_eop;
    logic                open;
    logic                close;
    logic [15:0]         client_port;
    logic [7:0]          dout;
    logic                dout_vld;
    logic                dout_sop;
    logic                dout_eop;
    tcp_pkg::tcp_state_e state;

    logic [31:0] rng = 32'hb07f;
    logic [31:0] rnd;
    logic [31:0] isn;
    logic [31:0] exp_snd;   // client seq the server expects next
    logic [31:0] exp_rcv;   // ack the client should carry
    logic        first_split;
    int          mismatches = 0;
    int          timeouts = 0;

    tcp_client_top #(
        .SERVER_PORT (SERVER_PORT)
    ) i_tcp_client_top (
        .clk         (clk),
        .rst         (rst),
        .din         (din),
        .din_vld     (din_vld),
        .din_sop     (din_sop),
        .din_eop     (din_eop),
        .open        (open),
        .close       (close),
        .client_port (client_port),
        .dout        (dout),
        .dout_vld    (dout_vld),
        .dout_sop    (dout_sop),
        .dout_eop    (dout_eop),
        .state       (state)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        mismatches++;
        $display("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    endtask

    task automatic check_state(input string what, input tcp_pkg::tcp_state_e want);
        if (state !== want) report_mismatch({what, " state"}, 32'(state), 32'(want));
    endtask

    task automatic wait_for_state(input tcp_pkg::tcp_state_e want, input int max_cycles);
        int k;
        k = 0;
        while (state !== want && k < max_cycles) begin
            @(negedge clk);
            k++;
        end
        if (state !== want) begin
            timeouts++;
            $display("timeout waiting for state %s, still in %s", want.name(), state.name());
        end
    endtask

    // server to client, one byte per valid cycle with random idle gaps
    task automatic send_segment(input logic [31:0] seq, input logic [31:0] ack,
                                input logic [5:0] flags, input int extra);
        logic [159:0] hdr;
        logic [31:0]  r;
        int           total;
        int           k;
        hdr   = {SERVER_PORT, client_port, seq, ack, 8'h50, 2'b00, flags, 16'hffff, 32'h0};
        total = 20 + extra;
        for (k = 0; k < total; k++) begin
            r = next_random();
            if (k > 0 && r[1:0] == 2'b00) begin
                repeat (1 + int'(r[2])) begin
                    @(posedge clk);
                    din_vld <= 1'b0;
                    din_sop <= 1'b0;
                    din_eop <= 1'b0;
                end
            end
            @(posedge clk);
            if (k < 20) din <= hdr[159 - 8*k -: 8];
            else din <= r[15:8];                       // payload, discarded by the DUT
            din_vld <= 1'b1;
            din_sop <= (k == 0);
            din_eop <= (k == total - 1);
        end
        @(posedge clk);
        din_vld <= 1'b0;
        din_sop <= 1'b0;
        din_eop <= 1'b0;
    endtask

    task automatic expect_frame(input string what, input logic [5:0] flags,
                                input logic [31:0] seq, input logic [31:0] ack,
                                input int latency_exp);
        tcp_pkg::tcp_seg_t seg;
        logic [159:0]      bits;
        logic              seen;
        int                latency;
        int                n;
        seen    = 1'b0;
        latency = 0;
        while (!seen && latency < 50) begin
            @(negedge clk);
            latency++;
            seen = dout_vld;
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: the DUT sent no %s frame", what);
            return;
        end
        if (latency != latency_exp) begin
            report_mismatch({what, " first byte latency"}, latency, latency_exp);
        end
        n    = 0;
        bits = '0;
        while (dout_vld === 1'b1 && n < 24) begin
            if (n < 20) bits = {bits[151:0], dout};
            if (dout_sop !== (n == 0)) begin
                report_mismatch({what, " dout_sop"}, 32'(dout_sop), 32'(n == 0));
            end
            if (dout_eop !== (n == 19)) begin
                report_mismatch({what, " dout_eop"}, 32'(dout_eop), 32'(n == 19));
            end
            n++;
            @(negedge clk);
        end
        if (n != 20) report_mismatch({what, " byte count"}, n, 20);
        seg.src_port = bits[159:144];
        seg.dst_port = bits[143:128];
        seg.seq      = bits[127:96];
        seg.ack      = bits[95:64];
        seg.flags    = bits[53:48];
        seg.window   = bits[47:32];
        if (seg.src_port !== client_port) begin
            report_mismatch({what, " src_port"}, 32'(seg.src_port), 32'(client_port));
        end
        if (seg.dst_port !== SERVER_PORT) begin
            report_mismatch({what, " dst_port"}, 32'(seg.dst_port), 32'(SERVER_PORT));
        end
        if (seg.seq !== seq) report_mismatch({what, " seq"}, seg.seq, seq);
        if (seg.ack !== ack) report_mismatch({what, " ack"}, seg.ack, ack);
        if (seg.flags !== flags) report_mismatch({what, " flags"}, {26'd0, seg.flags}, 32'(flags));
        if (seg.window !== 16'hffff) report_mismatch({what, " window"}, 32'(seg.window), 32'hffff);
        if (bits[63:54] !== 10'h140) begin
            report_mismatch({what, " offset bits"}, 32'(bits[63:54]), 32'h140);
        end
        if (bits[31:0] !== 32'h0) begin
            report_mismatch({what, " checksum and urgent"}, bits[31:0], 32'h0);
        end
    endtask

    task automatic expect_no_frame(input string what, input int cycles);
        logic reported;
        int   k;
        reported = 1'b0;
        for (k = 0; k < cycles; k++) begin
            @(negedge clk);
            if (dout_vld !== 1'b0 && !reported) begin
                report_mismatch({what, " dout_vld"}, 32'(dout_vld), 32'd0);
                reported = 1'b1;
            end
        end
    endtask

    task automatic start_connection(input string what);
        rnd = next_random();
        @(posedge clk);
        client_port <= rnd[15:0];
        open        <= 1'b1;
        @(posedge clk);
        open <= 1'b0;
        expect_frame({what, " SYN"}, F_SYN, 32'd0, 32'd0, 2);
        exp_snd = 32'd1;
        exp_rcv = 32'd0;
        check_state({what, " SYN"}, tcp_pkg::ST_SYN_SENT);
    endtask

    task automatic finish_handshake(input string what);
        isn = next_random();
        rnd = next_random();
        send_segment(isn, exp_snd, F_SYN | F_ACK, 1 + int'(rnd[2:0]));
        exp_rcv = isn + 32'd1;
        expect_frame({what, " handshake ACK"}, F_ACK, exp_snd, exp_rcv, 3);
        check_state({what, " handshake"}, tcp_pkg::ST_ESTABLISHED);
    endtask

    // split: server ACKs the FIN alone and sends its own FIN later
    task automatic close_connection(input string what, input logic split);
        rnd = next_random();
        @(posedge clk);
        close <= 1'b1;
        @(posedge clk);
        close <= 1'b0;
        expect_frame({what, " close FIN"}, F_FIN | F_ACK, exp_snd, exp_rcv, 2);
        exp_snd = exp_snd + 32'd1;
        check_state({what, " close"}, tcp_pkg::ST_FIN_WAIT);
        if (split) begin
            send_segment(exp_rcv, exp_snd, F_ACK, 0);
            expect_no_frame({what, " server ACK of FIN"}, 12);
            check_state({what, " server ACK of FIN"}, tcp_pkg::ST_TIME_WAIT);
        end
        send_segment(exp_rcv, exp_snd, F_FIN | F_ACK, int'(rnd[3:1]));
        exp_rcv = exp_rcv + 32'd1;
        expect_frame({what, " final ACK"}, F_ACK, exp_snd, exp_rcv, 3);
        wait_for_state(tcp_pkg::ST_IDLE, 10);
    endtask

    initial begin
        rst         = 1'b1;
        din         = 8'h00;
        din_vld     = 1'b0;
        din_sop     = 1'b0;
        din_eop     = 1'b0;
        open        = 1'b0;
        close       = 1'b0;
        client_port = 16'h0000;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        if (dout_vld !== 1'b0) report_mismatch("dout_vld after reset", 32'(dout_vld), 32'd0);
        check_state("after reset", tcp_pkg::ST_IDLE);
        start_connection("first");

        // even ack can never match snd_nxt of 1
        rnd = next_random();
        send_segment(next_random(), {rnd[31:1], 1'b0}, F_SYN | F_ACK, 0);
        expect_no_frame("wrong ack", 40);
        check_state("wrong ack", tcp_pkg::ST_SYN_SENT);
        finish_handshake("first");

        rnd = next_random();
        first_split = rnd[0];
        close_connection("first", first_split);

        // the other close style on a second connection
        start_connection("second");
        finish_handshake("second");
        close_connection("second", !first_split);

        start_connection("third");
        finish_handshake("third");
        send_segment(exp_rcv, exp_snd, F_RST | F_ACK, 0);
        expect_no_frame("RST", 30);
        check_state("after RST", tcp_pkg::ST_IDLE);

        $display("mismatches: %0d, timeouts: %0d", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: files.f
design/tcp_pkg.sv
design/tcp_header_rx.sv
design/tcp_header_tx.sv
design/tcp_conn_ctrl.sv
design/tcp_client_top.sv
verification/tcp_client_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the TCP client testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary -j 0 --top-module tcp_client_tb -f files.f -o tcp_client_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tcp_client_sim)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" <<< "$out"; then
    exit 0
fi
exit 1
